// ==== include/div_cfg.svh ====
`ifndef DIV_CFG_SVH
`define DIV_CFG_SVH

// Operand and result width
`define DIV_WIDTH 32

// Request to result, in cycles
// One magnitude stage, one stage per quotient bit, one sign stage
`define DIV_LATENCY (`DIV_WIDTH + 2)

`endif

// ==== hw/div_pkg.sv ====
`include "div_cfg.svh"

package div_pkg;

	// Execute command codes of the divide lane
	// Other codes can show up on the bus and read as a quotient request
	typedef enum logic [4:0] {
		EXE_DIV_DIV  = 5'h10,
		EXE_DIV_MOD  = 5'h11,
		EXE_DIV_UDIV = 5'h12,
		EXE_DIV_UMOD = 5'h13
	} exe_cmd_t;

	// One divide request
	typedef struct packed {
		// Signed operands when set
		logic sign;
		logic [`DIV_WIDTH-1:0] dividend;
		logic [`DIV_WIDTH-1:0] divisor;
	} div_req_t;

	// Divider answer, both halves at once
	typedef struct packed {
		logic [`DIV_WIDTH-1:0] quotient;
		logic [`DIV_WIDTH-1:0] remainder;
	} div_res_t;

endpackage

// ==== hw/div_radix2_pipe.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "div_cfg.svh"

module div_radix2_pipe (
	input logic iCLOCK,
	input logic inRESET,
	input logic flush,
	input logic in_valid,
	input div_pkg::div_req_t req,
	output logic out_valid,
	output div_pkg::div_res_t res
);
	import div_pkg::*;

	localparam int W = `DIV_WIDTH;

	// State carried from stage to stage
	typedef struct packed {
		logic neg_q;
		logic neg_r;
		logic zero;
		logic [W-1:0] divisor;
		logic [W-1:0] rem;
		// Dividend bits shift out at the top, quotient bits in at the bottom
		logic [W-1:0] aq;
	} div_stage_t;

	logic stage_vld [0:W];
	div_stage_t stage_q [0:W];

	logic neg_a;
	logic neg_b;
	div_stage_t stage_in;

	div_res_t res_nxt;
	logic out_zero;
	logic out_neg_q;

	// Input stage, magnitudes and sign flags
	assign neg_a = req.sign && req.dividend[W-1];
	assign neg_b = req.sign && req.divisor[W-1];

	always_comb begin
		stage_in.neg_q = neg_a ^ neg_b;
		stage_in.neg_r = neg_a;
		stage_in.zero = (req.divisor == '0);
		stage_in.divisor = neg_b ? -req.divisor : req.divisor;
		stage_in.rem = '0;
		// Most negative value maps onto 2**(W-1), still fits unsigned
		stage_in.aq = neg_a ? -req.dividend : req.dividend;
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			stage_vld[0] <= 1'b0;
		end
		else if (flush) begin
			stage_vld[0] <= 1'b0;
		end
		else begin
			stage_vld[0] <= in_valid;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (in_valid) begin
			stage_q[0] <= stage_in;
		end
	end

	// Restoring steps, one quotient bit each
	genvar k;
	generate
		for (k = 0; k < W; k++) begin : g_step
			logic [W:0] trial;
			logic [W:0] diff;
			logic q_bit;
			div_stage_t step_nxt;

			assign trial = {stage_q[k].rem, stage_q[k].aq[W-1]};
			assign diff = trial - {1'b0, stage_q[k].divisor};
			// No borrow means the divisor fits
			assign q_bit = !diff[W];

			always_comb begin
				step_nxt = stage_q[k];
				step_nxt.rem = q_bit ? diff[W-1:0] : trial[W-1:0];
				step_nxt.aq = {stage_q[k].aq[W-2:0], q_bit};
			end

			always_ff @(posedge iCLOCK or negedge inRESET) begin
				if (!inRESET) begin
					stage_vld[k+1] <= 1'b0;
				end
				else if (flush) begin
					stage_vld[k+1] <= 1'b0;
				end
				else begin
					stage_vld[k+1] <= stage_vld[k];
				end
			end

			always_ff @(posedge iCLOCK) begin
				if (stage_vld[k]) begin
					stage_q[k+1] <= step_nxt;
				end
			end
		end
	endgenerate

	// Output stage, sign correction
	// Zero divisor lands on all ones quotient and dividend remainder here
	always_comb begin
		res_nxt.quotient = stage_q[W].neg_q ? -stage_q[W].aq : stage_q[W].aq;
		res_nxt.remainder = stage_q[W].neg_r ? -stage_q[W].rem : stage_q[W].rem;
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			out_valid <= 1'b0;
		end
		else if (flush) begin
			out_valid <= 1'b0;
		end
		else begin
			out_valid <= stage_vld[W];
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (stage_vld[W]) begin
			res <= res_nxt;
			out_zero <= stage_q[W].zero;
			out_neg_q <= stage_q[W].neg_q;
		end
	end

	a_out_valid_known: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		!$isunknown(out_valid)
	) else $error("out_valid unknown");

	// Divide by zero gives -1, or +1 for a negative signed dividend
	a_zero_divisor_q: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		(out_valid && out_zero) |-> (res.quotient == (out_neg_q ? W'(1) : {W{1'b1}}))
	) else $error("zero divisor quotient %h", res.quotient);

endmodule

`default_nettype wire

// ==== hw/execute_div.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "div_cfg.svh"

module execute_div (
	input logic iCLOCK,
	input logic inRESET,
	input logic reset_sync,
	input logic prev_valid,
	input logic prev_udiv,
	input logic prev_sdiv,
	input div_pkg::exe_cmd_t cmd,
	input logic [`DIV_WIDTH-1:0] data_0,
	input logic [`DIV_WIDTH-1:0] data_1,
	input logic busy,
	output logic flag_waiting_div,
	output logic data_valid,
	output logic [`DIV_WIDTH-1:0] data
);
	import div_pkg::*;

	typedef enum logic {
		ST_IDLE = 1'b0,
		ST_WAIT = 1'b1
	} div_state_t;

	div_state_t state;
	logic start;
	logic want_rem;
	logic rem_sel;
	div_req_t div_req;
	div_res_t div_res;
	logic div_out_valid;

	// Only one divide in flight
	assign start = prev_valid && (prev_udiv || prev_sdiv) && !busy && (state == ST_IDLE);

	assign want_rem = (prev_udiv && (cmd == EXE_DIV_UMOD)) ||
		(prev_sdiv && (cmd == EXE_DIV_MOD));

	always_comb begin
		div_req.sign = prev_sdiv;
		div_req.dividend = data_0;
		div_req.divisor = data_1;
	end

	div_radix2_pipe div_radix2_pipe_inst (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.flush(reset_sync),
		.in_valid(start),
		.req(div_req),
		.out_valid(div_out_valid),
		.res(div_res)
	);

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= ST_IDLE;
		end
		else if (reset_sync) begin
			state <= ST_IDLE;
		end
		else begin
			case (state)
				ST_IDLE: begin
					if (start) begin
						state <= ST_WAIT;
					end
				end
				ST_WAIT: begin
					if (div_out_valid) begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Quotient or remainder, fixed at the start
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			rem_sel <= 1'b0;
		end
		else if (reset_sync) begin
			rem_sel <= 1'b0;
		end
		else if (start) begin
			rem_sel <= want_rem;
		end
	end

	assign flag_waiting_div = (state == ST_WAIT);
	assign data_valid = div_out_valid;
	assign data = rem_sel ? div_res.remainder : div_res.quotient;

	a_div_kind_onehot: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		prev_valid |-> !(prev_udiv && prev_sdiv)
	) else $error("prev_udiv and prev_sdiv both set");

	a_valid_while_waiting: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		data_valid |-> (state == ST_WAIT)
	) else $error("data_valid outside of wait state");

	// Result lands a fixed distance after the start unless flushed
	a_start_to_result: assert property (
		@(posedge iCLOCK) disable iff (!inRESET || reset_sync)
		start |-> ##(`DIV_LATENCY) data_valid
	) else $error("divide result missing after start");

endmodule

`default_nettype wire

// ==== hw/div_unit_top.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "div_cfg.svh"

// Integer divide lane of the execute stage
module div_unit_top (
	input logic iCLOCK,
	input logic inRESET,
	input logic reset_sync,
	// Previous stage
	input logic prev_valid,
	input logic prev_udiv,
	input logic prev_sdiv,
	input div_pkg::exe_cmd_t cmd,
	input logic [`DIV_WIDTH-1:0] data_0,
	input logic [`DIV_WIDTH-1:0] data_1,
	// Writeback side
	input logic busy,
	output logic flag_waiting_div,
	output logic data_valid,
	output logic [`DIV_WIDTH-1:0] data
);

	execute_div execute_div_inst (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.reset_sync(reset_sync),
		.prev_valid(prev_valid),
		.prev_udiv(prev_udiv),
		.prev_sdiv(prev_sdiv),
		.cmd(cmd),
		.data_0(data_0),
		.data_1(data_1),
		.busy(busy),
		.flag_waiting_div(flag_waiting_div),
		.data_valid(data_valid),
		.data(data)
	);

endmodule

`default_nettype wire

// ==== verification/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock (
	output logic iCLOCK,
	output logic inRESET
);
	localparam int RESET_CYCLES = 10;

	// 40 ns period
	initial begin
		iCLOCK = 1'b0;
		forever begin
			#20 iCLOCK = ~iCLOCK;
		end
	end

	initial begin
		inRESET = 1'b0;
		repeat (RESET_CYCLES) @(posedge iCLOCK);
		#2;
		inRESET = 1'b1;
	end

endmodule

// ==== verification/tb_div_unit.sv ====
`timescale 1ns/100ps
`include "div_cfg.svh"

module tb_div_unit;
	import div_pkg::*;

	localparam int W = `DIV_WIDTH;
	localparam int LAT = `DIV_LATENCY;
	localparam int TIMEOUT = 100;
	localparam logic [W-1:0] MIN_NEG = {1'b1, {(W-1){1'b0}}};
	localparam logic [W-1:0] ALL_ONES = {W{1'b1}};

	logic iCLOCK;
	logic inRESET;
	logic reset_sync;
	logic prev_valid;
	logic prev_udiv;
	logic prev_sdiv;
	exe_cmd_t cmd;
	logic [W-1:0] data_0;
	logic [W-1:0] data_1;
	logic busy;
	logic flag_waiting_div;
	logic data_valid;
	logic [W-1:0] data;

	logic start_edge;
	int checks;
	int errors;
	int ops;

	tb_clock tb_clock_inst (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET)
	);

	div_unit_top div_unit_top_inst (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.reset_sync(reset_sync),
		.prev_valid(prev_valid),
		.prev_udiv(prev_udiv),
		.prev_sdiv(prev_sdiv),
		.cmd(cmd),
		.data_0(data_0),
		.data_1(data_1),
		.busy(busy),
		.flag_waiting_div(flag_waiting_div),
		.data_valid(data_valid),
		.data(data)
	);

	// Start rule as seen from the ports
	assign start_edge = prev_valid && (prev_udiv || prev_sdiv) && !busy && !flag_waiting_div;

	a_result_latency: assert property (
		@(posedge iCLOCK) disable iff (!inRESET || reset_sync)
		start_edge |-> ##(LAT) data_valid
	) else begin
		errors++;
		$display("At %0t a started divide gave no data_valid %0d cycles later", $time, LAT);
	end

	a_waiting_window: assert property (
		@(posedge iCLOCK) disable iff (!inRESET || reset_sync)
		start_edge |=> flag_waiting_div [*LAT] ##1 !flag_waiting_div
	) else begin
		errors++;
		$display("At %0t flag_waiting_div did not span start to result", $time);
	end

	// Busy, no divide bit or no offer keeps the wrapper idle
	a_idle_holds: assert property (
		@(posedge iCLOCK) disable iff (!inRESET || reset_sync)
		(!start_edge && !flag_waiting_div) |=> !flag_waiting_div
	) else begin
		errors++;
		$display("At %0t the wrapper left idle without a valid start", $time);
	end

	a_single_pulse: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		data_valid |=> !data_valid [*LAT]
	) else begin
		errors++;
		$display("At %0t a second data_valid pulse came too early", $time);
	end

	a_pulse_in_wait: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		data_valid |-> flag_waiting_div
	) else begin
		errors++;
		$display("At %0t data_valid pulsed while not waiting", $time);
	end

	a_flush_clears: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		reset_sync |=> (!flag_waiting_div && !data_valid)
	) else begin
		errors++;
		$display("At %0t reset_sync left the wrapper busy or valid", $time);
	end

	function automatic logic picks_remainder(input logic sgn, input exe_cmd_t c);
		return (!sgn && c == EXE_DIV_UMOD) || (sgn && c == EXE_DIV_MOD);
	endfunction

	// Reference division rules
	function automatic logic [W-1:0] model_div(input logic sgn, input logic rem,
		input logic [W-1:0] a, input logic [W-1:0] b);
		logic [W-1:0] q;
		logic [W-1:0] r;
		if (b == '0) begin
			r = a;
			q = (sgn && a[W-1]) ? W'(1) : ALL_ONES;
		end
		else if (sgn && a == MIN_NEG && b == ALL_ONES) begin
			q = a;
			r = '0;
		end
		else if (sgn) begin
			q = $signed(a) / $signed(b);
			r = $signed(a) % $signed(b);
		end
		else begin
			q = a / b;
			r = a % b;
		end
		return rem ? r : q;
	endfunction

	function automatic logic [W-1:0] rand_operand();
		return $urandom >> ($urandom % W);
	endfunction

	task automatic step();
		@(posedge iCLOCK);
		#2;
	endtask

	task automatic drop_offer();
		prev_valid = 1'b0;
		prev_udiv = 1'b0;
		prev_sdiv = 1'b0;
	endtask

	task automatic offer(input logic sgn, input exe_cmd_t c, input logic [W-1:0] a,
		input logic [W-1:0] b);
		prev_valid = 1'b1;
		prev_udiv = !sgn;
		prev_sdiv = sgn;
		cmd = c;
		data_0 = a;
		data_1 = b;
	endtask

	// One divide from offer to checked result
	task automatic run_op(input logic sgn, input exe_cmd_t c, input logic [W-1:0] a,
		input logic [W-1:0] b, input int busy_cycles, input bit keep_offer);
		logic [W-1:0] expected;
		int n;
		bit seen;
		expected = model_div(sgn, picks_remainder(sgn, c), a, b);
		offer(sgn, c, a, b);
		busy = (busy_cycles > 0);
		for (n = 0; n < busy_cycles; n++) begin
			step();
		end
		busy = 1'b0;
		seen = 1'b0;
		for (n = 0; n < TIMEOUT && !seen; n++) begin
			step();
			seen = flag_waiting_div;
		end
		if (!seen) begin
			errors++;
			$display("Timeout at %0t, divide %h / %h was never started", $time, a, b);
			drop_offer();
			return;
		end
		if (!keep_offer) begin
			drop_offer();
		end
		seen = 1'b0;
		for (n = 0; n < TIMEOUT && !seen; n++) begin
			step();
			seen = data_valid;
		end
		drop_offer();
		if (!seen) begin
			errors++;
			$display("Timeout at %0t, no data_valid for divide %h / %h", $time, a, b);
			return;
		end
		checks++;
		ops++;
		assert (data == expected) else begin
			errors++;
			$display("ERR %0t data: expected %h, got %h (a=%h b=%h sign=%b cmd=%h)",
				$time, expected, data, a, b, sgn, c);
		end
	endtask

	task automatic report_test(input string name, input int err_before, input int ops_before);
		$display("Test %s finished, %0d operations, %0d errors", name, ops - ops_before,
			errors - err_before);
	endtask

	task automatic test_unsigned();
		int i;
		int j;
		int e0;
		int o0;
		logic [W-1:0] edge_val [0:2];
		e0 = errors;
		o0 = ops;
		for (i = 0; i < 200; i++) begin
			run_op(1'b0, (i % 2) ? EXE_DIV_UMOD : EXE_DIV_UDIV, $urandom, rand_operand(), 0, 0);
		end
		edge_val[0] = '0;
		edge_val[1] = W'(1);
		edge_val[2] = ALL_ONES;
		for (i = 0; i < 3; i++) begin
			for (j = 0; j < 3; j++) begin
				run_op(1'b0, EXE_DIV_UDIV, edge_val[i], edge_val[j], 0, 0);
				run_op(1'b0, EXE_DIV_UMOD, edge_val[i], edge_val[j], 0, 0);
			end
		end
		// Unlisted code, reads as quotient
		run_op(1'b0, exe_cmd_t'(5'h03), 32'd100, 32'd7, 0, 0);
		report_test("unsigned", e0, o0);
	endtask

	task automatic test_signed();
		int i;
		int mix;
		int e0;
		int o0;
		logic [W-1:0] a;
		logic [W-1:0] b;
		e0 = errors;
		o0 = ops;
		for (i = 0; i < 100; i++) begin
			mix = i % 4;
			a = rand_operand();
			b = rand_operand();
			if (mix[0]) begin
				a = -a;
			end
			if (mix[1]) begin
				b = -b;
			end
			run_op(1'b1, ((i / 4) % 2) ? EXE_DIV_MOD : EXE_DIV_DIV, a, b, 0, 0);
		end
		run_op(1'b1, EXE_DIV_DIV, MIN_NEG, ALL_ONES, 0, 0);
		run_op(1'b1, EXE_DIV_MOD, MIN_NEG, ALL_ONES, 0, 0);
		run_op(1'b1, EXE_DIV_DIV, MIN_NEG, W'(1), 0, 0);
		run_op(1'b1, EXE_DIV_MOD, MIN_NEG, MIN_NEG, 0, 0);
		run_op(1'b1, EXE_DIV_MOD, -W'(7), W'(2), 0, 0);
		run_op(1'b1, EXE_DIV_MOD, W'(7), -W'(2), 0, 0);
		run_op(1'b1, EXE_DIV_DIV, -W'(7), -W'(2), 0, 0);
		// UMOD with the signed bit still returns the quotient
		run_op(1'b1, EXE_DIV_UMOD, -W'(9), W'(4), 0, 0);
		report_test("signed", e0, o0);
	endtask

	task automatic test_zero_divisor();
		int e0;
		int o0;
		e0 = errors;
		o0 = ops;
		run_op(1'b0, EXE_DIV_UDIV, $urandom, '0, 0, 0);
		run_op(1'b0, EXE_DIV_UMOD, $urandom, '0, 0, 0);
		run_op(1'b0, EXE_DIV_UMOD, ALL_ONES, '0, 0, 0);
		run_op(1'b1, EXE_DIV_DIV, W'(5), '0, 0, 0);
		run_op(1'b1, EXE_DIV_DIV, -W'(5), '0, 0, 0);
		run_op(1'b1, EXE_DIV_DIV, MIN_NEG, '0, 0, 0);
		run_op(1'b1, EXE_DIV_DIV, '0, '0, 0, 0);
		run_op(1'b1, EXE_DIV_MOD, -W'(5), '0, 0, 0);
		run_op(1'b1, EXE_DIV_MOD, W'(5), '0, 0, 0);
		report_test("zero divisor", e0, o0);
	endtask

	task automatic test_timing();
		int e0;
		int o0;
		e0 = errors;
		o0 = ops;
		run_op(1'b0, EXE_DIV_UDIV, 32'd1000, 32'd3, 6, 0);
		// Offer left up for the whole wait
		run_op(1'b1, EXE_DIV_MOD, -W'(1000), W'(3), 0, 1);
		run_op(1'b0, EXE_DIV_UMOD, $urandom, rand_operand(), 0, 1);
		run_op(1'b1, EXE_DIV_DIV, $urandom, rand_operand(), 3, 1);
		report_test("timing", e0, o0);
	endtask

	task automatic test_flush();
		int n;
		int e0;
		int o0;
		bit seen;
		e0 = errors;
		o0 = ops;
		offer(1'b0, EXE_DIV_UDIV, 32'd12345, 32'd11);
		seen = 1'b0;
		for (n = 0; n < TIMEOUT && !seen; n++) begin
			step();
			seen = flag_waiting_div;
		end
		drop_offer();
		if (!seen) begin
			errors++;
			$display("Timeout at %0t, divide before flush was never started", $time);
		end
		repeat (10) step();
		reset_sync = 1'b1;
		step();
		reset_sync = 1'b0;
		checks++;
		assert (!flag_waiting_div) else begin
			errors++;
			$display("ERR %0t flag_waiting_div: expected 0, got %b", $time, flag_waiting_div);
		end
		for (n = 0; n < LAT + 5; n++) begin
			step();
			checks++;
			assert (!data_valid) else begin
				errors++;
				$display("At %0t a flushed divide still produced data_valid", $time);
			end
		end
		run_op(1'b1, EXE_DIV_DIV, -W'(12345), W'(11), 0, 0);
		report_test("flush", e0, o0);
	endtask

	task automatic test_no_divide();
		int n;
		int e0;
		int o0;
		e0 = errors;
		o0 = ops;
		offer(1'b0, EXE_DIV_UDIV, 32'd50, 32'd5);
		prev_udiv = 1'b0;
		for (n = 0; n < LAT + 5; n++) begin
			step();
			checks++;
			assert (!flag_waiting_div && !data_valid) else begin
				errors++;
				$display("At %0t an offer without a divide bit started a divide", $time);
			end
		end
		drop_offer();
		report_test("no divide bit", e0, o0);
	endtask

	initial begin
		int n;
		void'($urandom(32'h8306));
		checks = 0;
		errors = 0;
		ops = 0;
		reset_sync = 1'b0;
		busy = 1'b0;
		cmd = EXE_DIV_UDIV;
		data_0 = '0;
		data_1 = '0;
		drop_offer();
		for (n = 0; n < TIMEOUT && !inRESET; n++) begin
			step();
		end
		if (!inRESET) begin
			errors++;
			$display("Reset was never released");
		end
		step();
		test_unsigned();
		test_signed();
		test_zero_divisor();
		test_timing();
		test_flush();
		test_no_divide();
		repeat (4) step();
		$display("Summary: %0d operations, %0d checks, %0d errors", ops, checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end
		else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+include
hw/div_pkg.sv
hw/div_radix2_pipe.sv
hw/execute_div.sv
hw/div_unit_top.sv
verification/tb_clock.sv
verification/tb_div_unit.sv

// ==== Bender.yml ====
package:
  name: div_unit

sources:
  - include_dirs:
      - include
    files:
      - hw/div_pkg.sv
      - hw/div_radix2_pipe.sv
      - hw/execute_div.sv
      - hw/div_unit_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/tb_clock.sv
      - verification/tb_div_unit.sv
